//--- verilog.f
source/sdramCfgPkg.sv
source/sdramCmdPkg.sv
source/sdramCmdDecoder.sv
source/sdramBankTracker.sv
source/sdramCasPipe.sv
source/sdramBurstEngine.sv
source/sdramArray.sv
source/sdramTop.sv
tb/sdramTop_props.sv
tb/sdramTb.sv

//--- run.sh
#!/bin/sh
# Build and run the SDRAM model testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --timing --assert --top-module sdramTb \
        -f verilog.f --Mdir "$buildDir" -o sdramSim; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$buildDir/sdramSim" > "$logFile" 2>&1; then
    cat "$logFile"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$logFile"

if grep -q "Result: FAILED" "$logFile"; then
    exit 1
fi
exit 0

//--- tb/sdramTb.sv
`timescale 1ns/1ps

module sdramTb;

    import sdramCfgPkg::*;
    import sdramCmdPkg::*;

    localparam int TbRowBits = 4;
    localparam int TbColBits = 6;
    localparam int ClkPeriod = 20;

    // Cycle budget of each test, used by the watchdog
    localparam int SeqBurstCycles   = 45;
    localparam int InterleaveCycles = 55;
    localparam int ByteMaskCycles   = 30;
    localparam int BurstStopCycles  = 30;
    localparam int BankCycles       = 50;
    localparam int MarginCycles     = 100;
    localparam int TimeoutCycles    = 4 + SeqBurstCycles + InterleaveCycles + ByteMaskCycles
                                    + BurstStopCycles + BankCycles + MarginCycles;

    // Strobes as csN, rasN, casN, weN
    localparam logic [3:0] StbNop       = 4'b0111;
    localparam logic [3:0] StbActive    = 4'b0011;
    localparam logic [3:0] StbRead      = 4'b0101;
    localparam logic [3:0] StbWrite     = 4'b0100;
    localparam logic [3:0] StbPrecharge = 4'b0010;
    localparam logic [3:0] StbBurstStop = 4'b0110;
    localparam logic [3:0] StbLoadMode  = 4'b0000;

    logic       Clk;
    logic       rst;
    sdramPins_t pins;
    data_t      dqIn;
    data_t      dqOut;
    byteMask_t  dqOe;

    data_t       refMem [NumBanks][2**TbRowBits][2**TbColBits];
    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;

    sdramTop #(
        .RowBits (TbRowBits),
        .ColBits (TbColBits)
    ) sdramTop_inst (
        .Clk   (Clk),
        .rst   (rst),
        .pins  (pins),
        .dqIn  (dqIn),
        .dqOut (dqOut),
        .dqOe  (dqOe)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the tests did not finish", TimeoutCycles);
        $display("Result: FAILED");
        $finish;
    end

    // ****************************************
    // Helpers
    // ****************************************

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic data_t nextData();
        data_t word;
        logic  fb;
        word = '0;
        for (int i = 0; i < DataBits; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            word      = {word[DataBits-2:0], fb};
        end
        return word;
    endfunction

    // Column of a beat inside the burst-aligned block
    function automatic int burstColumn(input int start, input int beat, input int len,
                                       input int interleaved);
        int span;
        int offset;
        span = len - 1;
        if (interleaved != 0) begin
            offset = (start ^ beat) & span;
        end else begin
            offset = (start + beat) & span;
        end
        return (start & ~span) | offset;
    endfunction

    // Drives one cycle from a falling edge and returns at the next one
    task automatic driveCycle(input logic [3:0] strobes, input int ba, input int addr,
                              input byteMask_t dqm, input data_t data);
        pins.csN  = strobes[3];
        pins.rasN = strobes[2];
        pins.casN = strobes[1];
        pins.weN  = strobes[0];
        pins.ba   = bank_t'(ba);
        pins.addr = addr_t'(addr);
        pins.dqm  = dqm;
        dqIn      = data;
        @(negedge Clk);
    endtask

    task automatic idleCycle();
        driveCycle(StbNop, 0, 0, '0, '0);
    endtask

    task automatic loadMode(input int len, input int interleaved, input int casLat);
        int blCode;
        int clCode;
        case (len)
            2:       blCode = 1;
            4:       blCode = 2;
            8:       blCode = 3;
            default: blCode = 0;
        endcase
        clCode = (casLat == 3) ? 3 : 2;
        driveCycle(StbLoadMode, 0, (clCode << 4) | (interleaved << 3) | blCode, '0, '0);
        idleCycle();
    endtask

    task automatic activate(input int ba, input int row);
        driveCycle(StbActive, ba, row, '0, '0);
    endtask

    task automatic precharge(input int ba, input int allBanks);
        driveCycle(StbPrecharge, ba, (allBanks != 0) ? 1024 : 0, '0, '0);
    endtask

    task automatic checkBeat(input string testName, input data_t expData, input byteMask_t expOe);
        data_t dataMask;
        dataMask = {{8{expOe[1]}}, {8{expOe[0]}}};
        checkCount++;
        if (dqOe !== expOe) begin
            errorCount++;
            $display("error: %s at %0t dqOe expected %b actual %b",
                     testName, $time, expOe, dqOe);
        end
        if ((dqOut & dataMask) !== (expData & dataMask)) begin
            errorCount++;
            $display("error: %s at %0t dqOut expected %h actual %h",
                     testName, $time, expData & dataMask, dqOut & dataMask);
        end
    endtask

    // Beat i is stored at edge n+i, masked bytes keep old data
    task automatic writeBurst(input int ba, input int row, input int col, input int len,
                              input int interleaved, input int maskBeat, input byteMask_t maskVal);
        int        beatCol;
        data_t     word;
        byteMask_t dqm;
        for (int i = 0; i < len; i++) begin
            beatCol = burstColumn(col, i, len, interleaved);
            word    = nextData();
            dqm     = (i == maskBeat) ? maskVal : '0;
            if (!dqm[0]) begin
                refMem[ba][row][beatCol][7:0] = word[7:0];
            end
            if (!dqm[1]) begin
                refMem[ba][row][beatCol][15:8] = word[15:8];
            end
            driveCycle((i == 0) ? StbWrite : StbNop, ba, col, dqm, word);
        end
        idleCycle();
    endtask

    // After cycle c the outputs show edge n+c, beat i lands at c = CL+i
    task automatic readBurst(input string testName, input int ba, input int row, input int col,
                             input int len, input int casLat, input int interleaved,
                             input int maskEdge, input byteMask_t maskVal);
        int        beat;
        byteMask_t dqm;
        byteMask_t expOe;
        data_t     expData;
        for (int c = 0; c <= casLat + len; c++) begin
            dqm = (c == maskEdge) ? maskVal : '0;
            driveCycle((c == 0) ? StbRead : StbNop, ba, col, dqm, '0);
            beat = c - casLat;
            if (beat >= 0 && beat < len) begin
                expData = refMem[ba][row][burstColumn(col, beat, len, interleaved)];
                expOe   = (maskEdge >= 0 && c == maskEdge + 2) ? ~maskVal : 2'b11;
            end else begin
                expData = '0;
                expOe   = '0;
            end
            checkBeat(testName, expData, expOe);
        end
    endtask

    // Stop at edge s leaves the last beat after edge s+CL-1
    task automatic readWithStop(input string testName, input int ba, input int row,
                                input int col, input int casLat, input int stopCall);
        int        beat;
        logic [3:0] strobes;
        for (int c = 0; c <= stopCall + casLat + 3; c++) begin
            if (c == 0) begin
                strobes = StbRead;
            end else if (c == stopCall) begin
                strobes = StbBurstStop;
            end else begin
                strobes = StbNop;
            end
            driveCycle(strobes, ba, col, '0, '0);
            beat = c - casLat;
            if (beat >= 0 && c < stopCall + casLat) begin
                checkBeat(testName, refMem[ba][row][col + beat], 2'b11);
            end else begin
                checkBeat(testName, '0, '0);
            end
        end
    endtask

    task automatic readClosedBank(input string testName, input int ba, input int col,
                                  input int cycles);
        for (int c = 0; c < cycles; c++) begin
            driveCycle((c == 0) ? StbRead : StbNop, ba, col, '0, '0);
            checkBeat(testName, '0, '0);
        end
    endtask

    // ****************************************
    // Directed tests
    // ****************************************
    task automatic testSeqBurst();
        precharge(0, 1);
        loadMode(4, 0, 2);
        activate(0, 2);
        writeBurst(0, 2, 6, 4, 0, -1, '0);
        readBurst("seqBurst", 0, 2, 6, 4, 2, 0, -1, '0);
        readBurst("seqBurst", 0, 2, 5, 4, 2, 0, -1, '0);
        // Write arrives as the earlier read would start and takes the bus over
        driveCycle(StbRead, 0, 5, '0, '0);
        idleCycle();
        writeBurst(0, 2, 6, 4, 0, -1, '0);
        readBurst("seqInterrupt", 0, 2, 6, 4, 2, 0, -1, '0);
    endtask

    task automatic testInterleave();
        precharge(0, 1);
        loadMode(8, 1, 2);
        activate(1, 5);
        writeBurst(1, 5, 5, 8, 1, -1, '0);
        // Single reads show where each beat landed
        loadMode(1, 0, 2);
        for (int col = 0; col < 8; col++) begin
            readBurst("interleave", 1, 5, col, 1, 2, 0, -1, '0);
        end
    endtask

    task automatic testByteMask();
        precharge(0, 1);
        loadMode(2, 0, 2);
        activate(3, 7);
        writeBurst(3, 7, 20, 2, 0, -1, '0);
        writeBurst(3, 7, 20, 2, 0, 1, 2'b01);
        readBurst("byteMask", 3, 7, 20, 2, 2, 0, -1, '0);
        readBurst("byteMask", 3, 7, 20, 2, 2, 0, 1, 2'b10);
    endtask

    task automatic testBurstStop();
        precharge(0, 1);
        loadMode(8, 0, 3);
        activate(2, 4);
        writeBurst(2, 4, 8, 8, 0, -1, '0);
        readWithStop("burstStop", 2, 4, 8, 3, 3);
    endtask

    task automatic testBanks();
        precharge(0, 1);
        loadMode(2, 0, 2);
        activate(0, 3);
        activate(2, 9);
        writeBurst(0, 3, 10, 2, 0, -1, '0);
        writeBurst(2, 9, 10, 2, 0, -1, '0);
        readBurst("banks", 0, 3, 10, 2, 2, 0, -1, '0);
        readBurst("banks", 2, 9, 10, 2, 2, 0, -1, '0);
        precharge(0, 1);
        readClosedBank("banksClosed", 0, 10, 5);
        activate(0, 3);
        activate(2, 9);
        readBurst("banksReopen", 0, 3, 10, 2, 2, 0, -1, '0);
        readBurst("banksReopen", 2, 9, 10, 2, 2, 0, -1, '0);
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        lfsrState  = 32'hee8c162a;
        rst        = 1'b1;
        pins       = '{csN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1,
                       ba: '0, addr: '0, dqm: '0};
        dqIn       = '0;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;
        idleCycle();
        checkBeat("reset", '0, '0);

        testSeqBurst();
        testInterleave();
        testByteMask();
        testBurstStop();
        testBanks();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb/sdramTop_props.sv
`timescale 1ns/1ps

module sdramTop_props (
    input logic                    Clk,
    input logic                    rst,
    input sdramCmdPkg::sdramPins_t pins,
    input sdramCfgPkg::modeReg_t   mode,
    input sdramCfgPkg::byteMask_t  dqOe
);

    import sdramCfgPkg::*;

    logic writeCmd;

    assign writeCmd = !pins.csN && ({pins.rasN, pins.casN, pins.weN} == 3'b100);

    // Output enables come out of reset cleared
    resetClearsOe: assert property (@(posedge Clk) rst |=> (dqOe == '0))
        else $error("dqOe still set in the cycle after reset");

    // No read data on the bus right after a write at CL 2
    writeLeavesBusFree: assert property (@(posedge Clk)
        (!rst && writeCmd && (mode.casLat == CasLat2)) |=> (dqOe == '0))
        else $error("dqOe set in the cycle after a write command");

    noOeDuringReset: assert property (@(posedge Clk) (rst && $past(rst)) |-> (dqOe == '0))
        else $error("dqOe set while reset is held");

endmodule

bind sdramTop sdramTop_props sdramTop_props_inst (
    .Clk  (Clk),
    .rst  (rst),
    .pins (pins),
    .mode (mode),
    .dqOe (dqOe)
);

//--- source/sdramTop.sv
`timescale 1ns/1ps

module sdramTop #(
    parameter int RowBits = 13,
    parameter int ColBits = 10
) (
    input  logic                    Clk,
    input  logic                    rst,
    input  sdramCmdPkg::sdramPins_t pins,
    input  sdramCfgPkg::data_t      dqIn,
    output sdramCfgPkg::data_t      dqOut,
    output sdramCfgPkg::byteMask_t  dqOe
);

    import sdramCfgPkg::*;
    import sdramCmdPkg::*;

    sdramCmd_t cmd;
    modeReg_t  mode;
    colCmd_t   colCmd;
    stopReq_t  stopReq;
    colCmd_t   startCmd;
    stopReq_t  stopOut;
    arrayReq_t arrayReq;

    // ****************************************
    // Command path
    // ****************************************
    sdramCmdDecoder sdramCmdDecoder_inst (
        .Clk  (Clk),
        .rst  (rst),
        .pins (pins),
        .cmd  (cmd),
        .mode (mode)
    );

    sdramBankTracker #(
        .RowBits (RowBits)
    ) sdramBankTracker_inst (
        .Clk     (Clk),
        .rst     (rst),
        .cmd     (cmd),
        .colCmd  (colCmd),
        .stopReq (stopReq)
    );

    sdramCasPipe sdramCasPipe_inst (
        .Clk      (Clk),
        .rst      (rst),
        .mode     (mode),
        .colCmd   (colCmd),
        .stopReq  (stopReq),
        .startCmd (startCmd),
        .stopOut  (stopOut)
    );

    // ****************************************
    // Data path
    // ****************************************
    sdramBurstEngine sdramBurstEngine_inst (
        .Clk      (Clk),
        .rst      (rst),
        .mode     (mode),
        .startCmd (startCmd),
        .stopOut  (stopOut),
        .dqm      (cmd.dqm),
        .arrayReq (arrayReq)
    );

    sdramArray #(
        .RowBits (RowBits),
        .ColBits (ColBits)
    ) sdramArray_inst (
        .Clk   (Clk),
        .rst   (rst),
        .req   (arrayReq),
        .dqIn  (dqIn),
        .dqOut (dqOut),
        .dqOe  (dqOe)
    );

endmodule

//--- source/sdramArray.sv
`timescale 1ns/1ps

module sdramArray #(
    parameter int RowBits = 13,
    parameter int ColBits = 10
) (
    input  logic                   Clk,
    input  logic                   rst,
    input  sdramCmdPkg::arrayReq_t req,
    input  sdramCfgPkg::data_t     dqIn,
    output sdramCfgPkg::data_t     dqOut,
    output sdramCfgPkg::byteMask_t dqOe
);

    import sdramCfgPkg::*;

    localparam int Depth   = NumBanks * (2 ** RowBits) * (2 ** ColBits);
    localparam int IdxBits = $clog2(Depth);

    data_t              mem [Depth];
    logic [IdxBits-1:0] idx;

    // Upper row and column bits dropped
    assign idx = {req.bank, req.row[RowBits-1:0], req.col[ColBits-1:0]};

    always_ff @(posedge Clk) begin
        for (int b = 0; b < NumBytes; b++) begin
            if (req.write && req.byteEn[b]) begin
                mem[idx][b*8 +: 8] <= dqIn[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (req.read) begin
            dqOut <= mem[idx];
        end
    end

    // Output enable per byte follows the read mask
    always_ff @(posedge Clk) begin
        if (rst) begin
            dqOe <= '0;
        end else begin
            dqOe <= req.read ? req.byteEn : '0;
        end
    end

endmodule

//--- source/sdramBurstEngine.sv
`timescale 1ns/1ps

module sdramBurstEngine (
    input  logic                   Clk,
    input  logic                   rst,
    input  sdramCfgPkg::modeReg_t  mode,
    input  sdramCmdPkg::colCmd_t   startCmd,
    input  sdramCmdPkg::stopReq_t  stopOut,
    input  sdramCfgPkg::byteMask_t dqm,
    output sdramCmdPkg::arrayReq_t arrayReq
);

    import sdramCfgPkg::*;
    import sdramCmdPkg::*;

    logic       active;
    logic       burstWrite;
    bank_t      burstBank;
    addr_t      burstRow;
    addr_t      startCol;
    addr_t      curCol;
    logic [2:0] beatCnt;
    logic [2:0] lastBeat;
    byteMask_t  dqmPrev;
    byteMask_t  readEn;
    logic       writeStart;
    logic       stopHit;

    // Column of a given beat, wrapping inside the aligned block
    function automatic addr_t colAt(input addr_t base, input logic [2:0] beat,
                                    input logic [2:0] span, input logic interleaved);
        logic [2:0] low;
        addr_t      wrap;
        low  = interleaved ? (base[2:0] ^ beat) : (base[2:0] + beat);
        wrap = addr_t'(span);
        return (base & ~wrap) | (addr_t'(low) & wrap);
    endfunction

    // Also the wrap mask
    always_comb begin
        case (mode.burstLen)
            BurstLen2: lastBeat = 3'd1;
            BurstLen4: lastBeat = 3'd3;
            BurstLen8: lastBeat = 3'd7;
            default:   lastBeat = 3'd0;
        endcase
    end

    assign writeStart = startCmd.valid && startCmd.isWrite;
    assign stopHit    = stopOut.valid && (stopOut.allBanks || stopOut.bank == burstBank);

    // ****************************************
    // Burst state
    // ****************************************
    always_ff @(posedge Clk) begin
        if (rst) begin
            active     <= 1'b0;
            burstWrite <= 1'b0;
        end else if (startCmd.valid) begin
            active     <= !startCmd.isWrite || (lastBeat != 3'd0);
            burstWrite <= startCmd.isWrite;
        end else if (active && (stopHit || beatCnt == lastBeat)) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        dqmPrev <= dqm;
        // Read beat carries the mask one cycle older than the pins
        readEn  <= ~dqmPrev;
        if (startCmd.valid) begin
            burstBank <= startCmd.bank;
            burstRow  <= startCmd.row;
            startCol  <= startCmd.col;
            // Write beat 0 is already out this cycle
            if (startCmd.isWrite) begin
                beatCnt <= 3'd1;
                curCol  <= colAt(startCmd.col, 3'd1, lastBeat, mode.interleaved);
            end else begin
                beatCnt <= 3'd0;
                curCol  <= startCmd.col;
            end
        end else if (active) begin
            beatCnt <= beatCnt + 3'd1;
            curCol  <= colAt(startCol, beatCnt + 3'd1, lastBeat, mode.interleaved);
        end
    end

    // ****************************************
    // Beat to the array
    // ****************************************
    always_comb begin
        arrayReq = '0;
        if (writeStart) begin
            arrayReq.write  = 1'b1;
            arrayReq.bank   = startCmd.bank;
            arrayReq.row    = startCmd.row;
            arrayReq.col    = startCmd.col;
            arrayReq.byteEn = ~dqm;
        end else if (active && !(burstWrite && stopHit)) begin
            arrayReq.read   = !burstWrite;
            arrayReq.write  = burstWrite;
            arrayReq.bank   = burstBank;
            arrayReq.row    = burstRow;
            arrayReq.col    = curCol;
            arrayReq.byteEn = burstWrite ? ~dqm : readEn;
        end
    end

endmodule

//--- source/sdramCasPipe.sv
`timescale 1ns/1ps

module sdramCasPipe (
    input  logic                  Clk,
    input  logic                  rst,
    input  sdramCfgPkg::modeReg_t mode,
    input  sdramCmdPkg::colCmd_t  colCmd,
    input  sdramCmdPkg::stopReq_t stopReq,
    output sdramCmdPkg::colCmd_t  startCmd,
    output sdramCmdPkg::stopReq_t stopOut
);

    import sdramCfgPkg::*;
    import sdramCmdPkg::*;

    colCmd_t  readStage [2];
    stopReq_t stopStage [2];
    colCmd_t  readTap;
    stopReq_t stopTap;
    logic     writeMode;
    logic     readIn;
    logic     stopNow;

    assign readIn  = colCmd.valid && !colCmd.isWrite;
    // Last burst handed on was a write, so a stop acts at once
    assign stopNow = stopReq.valid && writeMode;

    always_ff @(posedge Clk) begin
        if (rst) begin
            readStage[0] <= '0;
            readStage[1] <= '0;
            stopStage[0] <= '0;
            stopStage[1] <= '0;
            writeMode    <= 1'b0;
        end else begin
            readStage[0] <= readIn ? colCmd : '0;
            readStage[1] <= readStage[0];
            stopStage[0] <= (stopReq.valid && !writeMode) ? stopReq : '0;
            stopStage[1] <= stopStage[0];
            if (startCmd.valid) begin
                writeMode <= startCmd.isWrite;
            end
        end
    end

    // Tap at CL-1
    assign readTap = (mode.casLat == CasLat3) ? readStage[1] : readStage[0];
    assign stopTap = (mode.casLat == CasLat3) ? stopStage[1] : stopStage[0];

    // Write bypasses latency and beats a read landing the same cycle
    assign startCmd = (colCmd.valid && colCmd.isWrite) ? colCmd : readTap;
    assign stopOut  = stopNow ? stopReq : stopTap;

endmodule

//--- source/sdramBankTracker.sv
`timescale 1ns/1ps

module sdramBankTracker #(
    parameter int RowBits = 13
) (
    input  logic                   Clk,
    input  logic                   rst,
    input  sdramCmdPkg::sdramCmd_t cmd,
    output sdramCmdPkg::colCmd_t   colCmd,
    output sdramCmdPkg::stopReq_t  stopReq
);

    import sdramCfgPkg::*;
    import sdramCmdPkg::*;

    logic [NumBanks-1:0] bankOpen;
    logic [RowBits-1:0]  openRow [NumBanks];
    logic                isColumn;

    assign isColumn = (cmd.op == OpRead) || (cmd.op == OpWrite);

    // Open flags, A10 on precharge closes every bank
    always_ff @(posedge Clk) begin
        if (rst) begin
            bankOpen <= '0;
        end else if (cmd.op == OpActive) begin
            bankOpen[cmd.ba] <= 1'b1;
        end else if (cmd.op == OpPrecharge) begin
            if (cmd.addr[10]) begin
                bankOpen <= '0;
            end else begin
                bankOpen[cmd.ba] <= 1'b0;
            end
        end
    end

    // Row is latched only when the bank was idle
    always_ff @(posedge Clk) begin
        if (cmd.op == OpActive && !bankOpen[cmd.ba]) begin
            openRow[cmd.ba] <= cmd.addr[RowBits-1:0];
        end
    end

    always_comb begin
        colCmd.valid   = isColumn && bankOpen[cmd.ba];
        colCmd.isWrite = (cmd.op == OpWrite);
        colCmd.bank    = cmd.ba;
        colCmd.row     = addr_t'(openRow[cmd.ba]);
        // A10 would request auto precharge, not supported here
        colCmd.col     = {cmd.addr[AddrBits-1:11], 1'b0, cmd.addr[9:0]};
    end

    always_comb begin
        stopReq.valid    = (cmd.op == OpBurstStop) || (cmd.op == OpPrecharge);
        stopReq.allBanks = (cmd.op == OpBurstStop) || cmd.addr[10];
        stopReq.bank     = cmd.ba;
    end

endmodule

//--- source/sdramCmdDecoder.sv
`timescale 1ns/1ps

module sdramCmdDecoder (
    input  logic                    Clk,
    input  logic                    rst,
    input  sdramCmdPkg::sdramPins_t pins,
    output sdramCmdPkg::sdramCmd_t  cmd,
    output sdramCfgPkg::modeReg_t   mode
);

    import sdramCfgPkg::*;
    import sdramCmdPkg::*;

    sdramOp_t op;
    modeReg_t loadVal;

    // Strobe pattern is RAS, CAS, WE
    always_comb begin
        if (pins.csN) begin
            op = OpNop;
        end else begin
            case ({pins.rasN, pins.casN, pins.weN})
                3'b011:  op = OpActive;
                3'b101:  op = OpRead;
                3'b100:  op = OpWrite;
                3'b010:  op = OpPrecharge;
                3'b110:  op = OpBurstStop;
                3'b000:  op = OpLoadMode;
                // Auto refresh lands here too
                default: op = OpNop;
            endcase
        end
    end

    assign cmd = '{op: op, ba: pins.ba, addr: pins.addr, dqm: pins.dqm};

    // ****************************************
    // Mode register
    // ****************************************
    always_comb begin
        case (pins.addr[2:0])
            3'b001:  loadVal.burstLen = BurstLen2;
            3'b010:  loadVal.burstLen = BurstLen4;
            3'b011:  loadVal.burstLen = BurstLen8;
            // Full page and reserved codes give a single beat
            default: loadVal.burstLen = BurstLen1;
        endcase
        loadVal.interleaved = pins.addr[3];
        loadVal.casLat      = (pins.addr[6:4] == 3'b011) ? CasLat3 : CasLat2;
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            mode <= '{burstLen: BurstLen1, interleaved: 1'b0, casLat: CasLat2};
        end else if (op == OpLoadMode) begin
            mode <= loadVal;
        end
    end

endmodule

//--- source/sdramCmdPkg.sv
package sdramCmdPkg;

    typedef enum logic [2:0] {
        OpNop,
        OpActive,
        OpRead,
        OpWrite,
        OpPrecharge,
        OpBurstStop,
        OpLoadMode
    } sdramOp_t;

    // Raw command pins, active low strobes
    typedef struct packed {
        logic                   csN;
        logic                   rasN;
        logic                   casN;
        logic                   weN;
        sdramCfgPkg::bank_t     ba;
        sdramCfgPkg::addr_t     addr;
        sdramCfgPkg::byteMask_t dqm;
    } sdramPins_t;

    typedef struct packed {
        sdramOp_t               op;
        sdramCfgPkg::bank_t     ba;
        sdramCfgPkg::addr_t     addr;
        sdramCfgPkg::byteMask_t dqm;
    } sdramCmd_t;

    typedef struct packed {
        logic               valid;
        logic               isWrite;
        sdramCfgPkg::bank_t bank;
        sdramCfgPkg::addr_t row;
        sdramCfgPkg::addr_t col;
    } colCmd_t;

    typedef struct packed {
        logic               valid;
        logic               allBanks;
        sdramCfgPkg::bank_t bank;
    } stopReq_t;

    // One beat towards the storage array
    typedef struct packed {
        logic                   read;
        logic                   write;
        sdramCfgPkg::bank_t     bank;
        sdramCfgPkg::addr_t     row;
        sdramCfgPkg::addr_t     col;
        sdramCfgPkg::byteMask_t byteEn;
    } arrayReq_t;

endpackage

//--- source/sdramCfgPkg.sv
package sdramCfgPkg;

    localparam int AddrBits = 13;
    localparam int DataBits = 16;
    localparam int NumBanks = 4;
    localparam int BankBits = $clog2(NumBanks);
    localparam int NumBytes = DataBits / 8;

    typedef logic [BankBits-1:0] bank_t;
    typedef logic [AddrBits-1:0] addr_t;
    typedef logic [DataBits-1:0] data_t;
    typedef logic [NumBytes-1:0] byteMask_t;

    // Burst length as kept in the mode register
    typedef enum logic [1:0] {
        BurstLen1 = 2'd0,
        BurstLen2 = 2'd1,
        BurstLen4 = 2'd2,
        BurstLen8 = 2'd3
    } burstLen_t;

    typedef enum logic {
        CasLat2 = 1'b0,
        CasLat3 = 1'b1
    } casLat_t;

    typedef struct packed {
        burstLen_t burstLen;
        logic      interleaved;
        casLat_t   casLat;
    } modeReg_t;

endpackage
